// ==== tb.f ====
rtl/knob_pkg.sv
rtl/display_pkg.sv
rtl/control_sync.sv
rtl/dram_event_monitor.sv
rtl/display_page_select.sv
rtl/seven_seg_scanner.sv
rtl/dram_status_top.sv
testbench/dram_status_props.sv
testbench/tb_dram_status.sv

// ==== Makefile ====
TOP := tb_dram_status

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): tb.f rtl/*.sv testbench/*.sv
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -qF '*** PASSED ***' sim.log

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// ==== testbench/tb_dram_status.sv ====
`timescale 1ns/1ps

module tb_dram_status;

    localparam int SCAN_DIV       = 4;
    localparam int DIGITS         = display_pkg::DIGIT_COUNT;
    localparam int SETTLE_CYCLES  = 8;
    localparam int SCAN_CYCLES    = DIGITS * SCAN_DIV;
    localparam int PULSE_ROUNDS   = 3;
    localparam int MAX_PULSES     = 256;
    localparam int MAX_GAP        = 3;
    localparam int WRAP_PULSES    = 65536 + 5;   // enough to roll the counter over
    localparam int KNOB_ROUNDS    = 2;
    localparam int ROUTE_ROUNDS   = 4;
    localparam int NUM_SCANS      = 1 + PULSE_ROUNDS + 1 + 6 * KNOB_ROUNDS + ROUTE_ROUNDS;
    localparam int TIMEOUT_CYCLES = 8 + NUM_SCANS * (SETTLE_CYCLES + SCAN_CYCLES + 4)
                                  + PULSE_ROUNDS * MAX_PULSES * (MAX_GAP + 1)
                                  + WRAP_PULSES + 1000;

    logic                     clk_dram_ctrl;
    logic                     rst;
    knob_pkg::knob_set_t      knobs;
    knob_pkg::route_set_t     routes;
    logic                     mem_complete;
    logic                     write_last;
    display_pkg::page_t       page;
    display_pkg::seg_t        cathode;
    logic [DIGITS-1:0]        anode;
    logic                     write_seen;

    logic [31:0] lfsr_state;
    logic [15:0] model_count;       // own pulse count, 16 bits so it wraps
    string       test_name;
    int          scan_req  = 0;
    int          scan_done = 0;

    initial clk_dram_ctrl = 1'b0;
    always #4 clk_dram_ctrl = ~clk_dram_ctrl;

    dram_status_top #(
        .SCAN_DIV (SCAN_DIV)
    ) dut0 (
        .i_clk_dram_ctrl (clk_dram_ctrl),
        .i_rst           (rst),
        .i_knobs         (knobs),
        .i_routes        (routes),
        .i_mem_complete  (mem_complete),
        .i_write_last    (write_last),
        .i_page          (page),
        .o_cathode       (cathode),
        .o_anode         (anode),
        .o_write_seen    (write_seen)
    );

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
    endtask

    task automatic randomize_knobs();
        logic [31:0] v;
        for (int i = 0; i < 12; i++) begin
            rand_bits(10, v);
            knobs[i*10 +: 10] = v[9:0];
        end
    endtask

    task automatic randomize_routes();
        logic [31:0] v;
        for (int i = 0; i < 6; i++) begin
            rand_bits(3, v);
            routes[i*3 +: 3] = v[2:0];
        end
    endtask

    // expected display word, straight from the page rules
    function automatic display_pkg::disp_word_t expected_word(
        input display_pkg::page_t   p,
        input knob_pkg::knob_set_t  k,
        input knob_pkg::route_set_t r,
        input logic [15:0]          count
    );
        logic [119:0]            flat;
        logic [17:0]             rflat;
        display_pkg::disp_word_t w;
        int                      top;
        flat  = k;
        rflat = r;
        w     = '0;
        if (p == 3'd0) begin
            w[15:0] = count;
        end else if (p == 3'd7) begin
            // output route in nibble 0 up to delay route in nibble 5
            for (int n = 0; n < 6; n++) begin
                w[n*4 +: 3] = rflat[17 - 3*n -: 3];
            end
        end else begin
            top      = 119 - 20 * (int'(p) - 1);  // volume sits at the top
            w[25:16] = flat[top -: 10];
            w[9:0]   = flat[top - 10 -: 10];
        end
        return w;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // hand one scan to the compare process and wait for it
    task automatic run_scan(input string name);
        test_name = name;
        repeat (SETTLE_CYCLES) @(negedge clk_dram_ctrl);
        scan_req++;
        wait (scan_done == scan_req);
    endtask

    task automatic send_pulses(input int count, input bit random_gaps);
        logic [31:0] v;
        for (int i = 0; i < count; i++) begin
            mem_complete = 1'b1;
            model_count  = model_count + 16'd1;
            @(negedge clk_dram_ctrl);
            mem_complete = 1'b0;
            if (random_gaps) begin
                rand_bits(2, v);
                repeat (int'(v[1:0])) @(negedge clk_dram_ctrl);
            end
        end
    endtask

    task automatic hold_write_seen(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk_dram_ctrl);
            check_value("write_seen held", 32'd1, 32'(write_seen));
        end
    endtask

    // compare process, one full scan per request
    initial begin : compare_scan
        display_pkg::disp_word_t exp_word;
        display_pkg::nibble_t    exp_nibble;
        int                      lit_cycles [DIGITS];
        int                      low_count;
        int                      digit;
        forever begin
            wait (scan_done < scan_req);
            exp_word = expected_word(page, knobs, routes, model_count);
            for (int d = 0; d < DIGITS; d++) begin
                lit_cycles[d] = 0;
            end
            repeat (SCAN_CYCLES) begin
                @(negedge clk_dram_ctrl);
                low_count = 0;
                digit     = 0;
                for (int d = 0; d < DIGITS; d++) begin
                    if (!anode[d]) begin
                        low_count++;
                        digit = d;
                    end
                end
                check_value({test_name, " anodes low"}, 32'd1, 32'(low_count));
                lit_cycles[digit]++;
                exp_nibble = exp_word[digit*4 +: 4];
                check_value($sformatf("%s digit %0d", test_name, digit),
                            32'(display_pkg::HEX_SEGMENTS[exp_nibble]), 32'(cathode));
            end
            // every digit lit for one dwell in a window of one scan
            for (int d = 0; d < DIGITS; d++) begin
                check_value($sformatf("%s dwell of digit %0d", test_name, d),
                            32'(SCAN_DIV), 32'(lit_cycles[d]));
            end
            scan_done++;
        end
    end

    initial begin : stimulus
        logic [31:0] v;
        int          pulses;
        rst          = 1'b1;
        knobs        = '0;
        routes       = '0;
        mem_complete = 1'b0;
        write_last   = 1'b0;
        page         = '0;
        lfsr_state   = 32'h046af4f5;
        model_count  = '0;
        repeat (8) @(negedge clk_dram_ctrl);
        rst = 1'b0;

        run_scan("reset page 0");
        check_value("reset write_seen", 32'd0, 32'(write_seen));

        for (int r = 0; r < PULSE_ROUNDS; r++) begin
            rand_bits(8, v);
            pulses = int'(v[7:0]) + 1;
            send_pulses(pulses, 1'b1);
            run_scan($sformatf("count round %0d", r));
        end
        send_pulses(WRAP_PULSES, 1'b0);
        run_scan("count wrap");

        for (int p = 1; p <= 6; p++) begin
            for (int r = 0; r < KNOB_ROUNDS; r++) begin
                randomize_knobs();
                page = 3'(p);
                run_scan($sformatf("knobs page %0d round %0d", p, r));
            end
        end

        page = 3'd7;
        for (int r = 0; r < ROUTE_ROUNDS; r++) begin
            randomize_routes();
            run_scan($sformatf("routes round %0d", r));
        end

        check_value("write_seen before pulse", 32'd0, 32'(write_seen));
        write_last = 1'b1;
        @(negedge clk_dram_ctrl);
        write_last = 1'b0;
        check_value("write_seen rise", 32'd1, 32'(write_seen));
        for (int r = 0; r < 3; r++) begin
            rand_bits(4, v);
            hold_write_seen(int'(v[3:0]) + 1);
            write_last = 1'b1;           // later pulses change nothing
            hold_write_seen(1);
            write_last = 1'b0;
        end
        hold_write_seen(8);

        $display("*** PASSED ***");
        $finish;
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk_dram_ctrl);
        $display("Timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("*** FAILED ***");
        $fatal(1, "timeout");
    end

endmodule

// ==== testbench/dram_status_props.sv ====
`timescale 1ns/1ps

module dram_status_props (
    input logic                                i_clk,
    input logic                                i_rst,
    input logic [display_pkg::DIGIT_COUNT-1:0] i_anode,
    input logic                                i_write_seen,
    input logic [15:0]                         i_complete_count
);

    // exactly one digit driven at any time
    one_anode_low: assert property (
        @(posedge i_clk) disable iff (i_rst)
        $onehot(~i_anode)
    ) else $error("anode bus %b does not have exactly one low bit", i_anode);

    // sticky flag only clears through reset
    write_seen_sticky: assert property (
        @(posedge i_clk) disable iff (i_rst)
        !$fell(i_write_seen)
    ) else $error("write_seen fell outside reset");

    // one completion per cycle at most, wrap included
    count_step: assert property (
        @(posedge i_clk) disable iff (i_rst)
        (i_complete_count == $past(i_complete_count)) ||
        (i_complete_count == $past(i_complete_count) + 16'd1)
    ) else $error("completion count jumped from %h to %h",
                  $past(i_complete_count), i_complete_count);

endmodule

// scanner anodes and event monitor outputs, as wired in the top level
bind dram_status_top dram_status_props u_status_props (
    .i_clk            (i_clk_dram_ctrl),
    .i_rst            (i_rst),
    .i_anode          (o_anode),
    .i_write_seen     (o_write_seen),
    .i_complete_count (complete_count)
);

// ==== rtl/dram_status_top.sv ====
`timescale 1ns/1ps

module dram_status_top #(
    parameter int SCAN_DIV = 1024   // cycles per lit digit
) (
    input  logic                                i_clk_dram_ctrl,
    input  logic                                i_rst,
    input  knob_pkg::knob_set_t                 i_knobs,
    input  knob_pkg::route_set_t                i_routes,
    input  logic                                i_mem_complete,
    input  logic                                i_write_last,
    input  display_pkg::page_t                  i_page,
    output display_pkg::seg_t                   o_cathode,
    output logic [display_pkg::DIGIT_COUNT-1:0] o_anode,
    output logic                                o_write_seen
);

    knob_pkg::knob_set_t     sync_knobs;
    knob_pkg::route_set_t    sync_routes;
    logic [15:0]             complete_count;
    display_pkg::disp_word_t disp_word;

    // knobs and routes come over from the control clock
    control_sync u_control_sync (
        .i_clk_dram_ctrl (i_clk_dram_ctrl),
        .i_rst           (i_rst),
        .i_knobs         (i_knobs),
        .i_routes        (i_routes),
        .o_knobs         (sync_knobs),
        .o_routes        (sync_routes)
    );

    dram_event_monitor u_dram_event_monitor (
        .i_clk_dram_ctrl  (i_clk_dram_ctrl),
        .i_rst            (i_rst),
        .i_mem_complete   (i_mem_complete),
        .i_write_last     (i_write_last),
        .o_complete_count (complete_count),
        .o_write_seen     (o_write_seen)
    );

    display_page_select u_display_page_select (
        .i_clk_dram_ctrl  (i_clk_dram_ctrl),
        .i_rst            (i_rst),
        .i_page           (i_page),
        .i_knobs          (sync_knobs),
        .i_routes         (sync_routes),
        .i_complete_count (complete_count),
        .o_word           (disp_word)
    );

    // one cathode bus shared by all eight digits
    seven_seg_scanner #(
        .SCAN_DIV (SCAN_DIV)
    ) u_seven_seg_scanner (
        .i_clk_dram_ctrl (i_clk_dram_ctrl),
        .i_rst           (i_rst),
        .i_word          (disp_word),
        .o_cathode       (o_cathode),
        .o_anode         (o_anode)
    );

endmodule

// ==== rtl/seven_seg_scanner.sv ====
`timescale 1ns/1ps

module seven_seg_scanner #(
    parameter int SCAN_DIV = 1024
) (
    input  logic                                i_clk_dram_ctrl,
    input  logic                                i_rst,
    input  display_pkg::disp_word_t             i_word,
    output display_pkg::seg_t                   o_cathode,
    output logic [display_pkg::DIGIT_COUNT-1:0] o_anode
);

    localparam int DIGIT_W = $clog2(display_pkg::DIGIT_COUNT);
    localparam int DWELL_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;
    localparam logic [DWELL_W-1:0] DWELL_LAST = DWELL_W'(SCAN_DIV - 1);
    localparam logic [DIGIT_W-1:0] DIGIT_LAST = DIGIT_W'(display_pkg::DIGIT_COUNT - 1);

    logic [DWELL_W-1:0] dwell_cnt;
    logic [DIGIT_W-1:0] digit_idx;
    logic               dwell_done;

    display_pkg::nibble_t                nibble;
    display_pkg::seg_t                   cathode_q;
    logic [display_pkg::DIGIT_COUNT-1:0] anode_q;

    assign dwell_done = (dwell_cnt == DWELL_LAST);

    // dwell timer and digit index
    always_ff @(posedge i_clk_dram_ctrl) begin
        if (i_rst) begin
            dwell_cnt <= '0;
            digit_idx <= '0;
        end else if (dwell_done) begin
            dwell_cnt <= '0;
            if (digit_idx == DIGIT_LAST) begin
                digit_idx <= '0;   // wrap to the rightmost digit
            end else begin
                digit_idx <= digit_idx + 1'b1;
            end
        end else begin
            dwell_cnt <= dwell_cnt + 1'b1;
        end
    end

    // digit k shows nibble k, counted from the lsb
    assign nibble = i_word[digit_idx*4 +: 4];

    // anode and cathode leave the same register, so the pattern never
    // lands on the wrong digit
    always_ff @(posedge i_clk_dram_ctrl) begin
        if (i_rst) begin
            anode_q   <= ~{{(display_pkg::DIGIT_COUNT-1){1'b0}}, 1'b1};
            cathode_q <= display_pkg::HEX_SEGMENTS[0];
        end else begin
            anode_q   <= ~(display_pkg::DIGIT_COUNT'(1) << digit_idx);  // one low
            cathode_q <= display_pkg::HEX_SEGMENTS[nibble];
        end
    end

    assign o_anode   = anode_q;
    assign o_cathode = cathode_q;

endmodule

// ==== rtl/display_page_select.sv ====
`timescale 1ns/1ps

module display_page_select (
    input  logic                    i_clk_dram_ctrl,
    input  logic                    i_rst,
    input  display_pkg::page_t      i_page,
    input  knob_pkg::knob_set_t     i_knobs,
    input  knob_pkg::route_set_t    i_routes,
    input  logic [15:0]             i_complete_count,
    output display_pkg::disp_word_t o_word
);

    display_pkg::disp_word_t word_next;
    display_pkg::disp_word_t word_q;

    // each knob gets four hex digits, zero extended
    always_comb begin
        case (i_page)
            3'd1: word_next = {6'b0, i_knobs.volume,
                               6'b0, i_knobs.pitch};
            3'd2: word_next = {6'b0, i_knobs.delay_wet,
                               6'b0, i_knobs.delay_rate};
            3'd3: word_next = {6'b0, i_knobs.delay_feedback,
                               6'b0, i_knobs.reverb_wet};
            3'd4: word_next = {6'b0, i_knobs.reverb_size,
                               6'b0, i_knobs.reverb_feedback};
            3'd5: word_next = {6'b0, i_knobs.filter_quality,
                               6'b0, i_knobs.filter_cutoff};
            3'd6: word_next = {6'b0, i_knobs.distortion_drive,
                               6'b0, i_knobs.crush_pressure};
            3'd7: begin
                // one route per digit, delay on the left
                word_next = {8'b0,
                             1'b0, i_routes.delay_src,
                             1'b0, i_routes.reverb_src,
                             1'b0, i_routes.filter_src,
                             1'b0, i_routes.distortion_src,
                             1'b0, i_routes.crush_src,
                             1'b0, i_routes.output_src};
            end
            default: word_next = {16'b0, i_complete_count};  // page 0
        endcase
    end

    always_ff @(posedge i_clk_dram_ctrl) begin
        if (i_rst) begin
            word_q <= '0;
        end else begin
            word_q <= word_next;
        end
    end

    assign o_word = word_q;

endmodule

// ==== rtl/dram_event_monitor.sv ====
`timescale 1ns/1ps

module dram_event_monitor (
    input  logic        i_clk_dram_ctrl,
    input  logic        i_rst,
    input  logic        i_mem_complete,
    input  logic        i_write_last,
    output logic [15:0] o_complete_count,
    output logic        o_write_seen
);

    logic [15:0] complete_count;
    logic        write_seen;

    // completed memory requests, wraps at 16 bits
    always_ff @(posedge i_clk_dram_ctrl) begin
        if (i_rst) begin
            complete_count <= '0;
        end else if (i_mem_complete) begin
            complete_count <= complete_count + 16'd1;
        end
    end

    // sticky flag, set by the first last beat of the sample write stream
    always_ff @(posedge i_clk_dram_ctrl) begin
        if (i_rst) begin
            write_seen <= 1'b0;
        end else if (i_write_last) begin
            write_seen <= 1'b1;
        end
    end

    assign o_complete_count = complete_count;
    assign o_write_seen     = write_seen;  // goes to an LED

endmodule

// ==== rtl/control_sync.sv ====
`timescale 1ns/1ps

module control_sync (
    input  logic                   i_clk_dram_ctrl,
    input  logic                   i_rst,
    input  knob_pkg::knob_set_t    i_knobs,
    input  knob_pkg::route_set_t   i_routes,
    output knob_pkg::knob_set_t    o_knobs,
    output knob_pkg::route_set_t   o_routes
);

    // first stage, may go metastable on a change
    knob_pkg::knob_set_t  knobs_meta;
    knob_pkg::route_set_t routes_meta;

    // second stage
    knob_pkg::knob_set_t  knobs_sync;
    knob_pkg::route_set_t routes_sync;

    always_ff @(posedge i_clk_dram_ctrl) begin
        if (i_rst) begin
            knobs_meta  <= '0;
            routes_meta <= '0;
            knobs_sync  <= '0;
            routes_sync <= '0;
        end else begin
            knobs_meta  <= i_knobs;
            routes_meta <= i_routes;
            knobs_sync  <= knobs_meta;   // settled copy
            routes_sync <= routes_meta;
        end
    end

    // knob values move slowly, so a torn word between fields only lasts
    // one cycle on the display
    assign o_knobs  = knobs_sync;
    assign o_routes = routes_sync;

endmodule

// ==== rtl/display_pkg.sv ====
package display_pkg;

    typedef logic [31:0] disp_word_t;  // all eight digits
    typedef logic [3:0]  nibble_t;     // one hex digit
    typedef logic [6:0]  seg_t;        // gfedcba, active low
    typedef logic [2:0]  page_t;       // page switch

    localparam int DIGIT_COUNT = 8;

    // hex digit to cathode pattern, a lit segment is a 0
    localparam seg_t HEX_SEGMENTS [16] = '{
        7'h40,  // 0
        7'h79,  // 1
        7'h24,  // 2
        7'h30,  // 3
        7'h19,  // 4
        7'h12,  // 5
        7'h02,  // 6
        7'h78,  // 7
        7'h00,  // 8
        7'h10,  // 9
        7'h08,  // A
        7'h03,  // b
        7'h46,  // C
        7'h21,  // d
        7'h06,  // E
        7'h0E   // F
    };

endpackage

// ==== rtl/knob_pkg.sv ====
package knob_pkg;

    // one potentiometer reading from the ADC scan
    typedef logic [9:0] knob_t;

    // patch source of one effect input
    typedef logic [2:0] route_t;

    // all twelve front panel knobs, volume in the top field
    typedef struct packed {
        knob_t volume;
        knob_t pitch;
        knob_t delay_wet;
        knob_t delay_rate;
        knob_t delay_feedback;
        knob_t reverb_wet;
        knob_t reverb_size;
        knob_t reverb_feedback;
        knob_t filter_quality;
        knob_t filter_cutoff;
        knob_t distortion_drive;
        knob_t crush_pressure;
    } knob_set_t;

    // patch matrix, one source per effect input
    typedef struct packed {
        route_t output_src;
        route_t crush_src;
        route_t distortion_src;
        route_t filter_src;
        route_t reverb_src;
        route_t delay_src;
    } route_set_t;

endpackage
